//--- logic/axis_reg_slice.sv
`timescale 1ns/10ps

module axis_reg_slice #(
   parameter type                    payload_t = stream_pkg::stream_word_t,
   parameter stream_pkg::slice_mode_e mode     = stream_pkg::SLICE_FULL
) (
   input  logic     ACLK,
   input  logic     ARESET,
   input  payload_t s_data_i,
   input  logic     s_valid_i,
   output logic     s_ready_o,
   output payload_t m_data_o,
   output logic     m_valid_o,
   input  logic     m_ready_i
);

   import stream_pkg::*;

   if (mode == SLICE_FULL) begin : g_full

      // **************************************
      // two entries, main plus skid
      // **************************************

      // bit 0 doubles as the output valid
      localparam logic [1:0] st_zero = 2'b10;
      localparam logic [1:0] st_one  = 2'b11;
      localparam logic [1:0] st_two  = 2'b01;

      logic [1:0] state_q;
      payload_t   main_q;
      payload_t   skid_q;
      logic       ready_q;
      logic [1:0] rst_d_q;
      logic       s_xfer;
      logic       load_main;
      logic       from_skid;

      assign s_xfer    = s_valid_i & ready_q;
      assign from_skid = (state_q == st_two);

      always_comb begin
         case (state_q)
            st_zero: load_main = s_xfer;
            st_one:  load_main = s_xfer & m_ready_i;
            st_two:  load_main = m_ready_i;
            default: load_main = 1'b0;
         endcase
      end

      always_ff @(posedge ACLK) begin
         rst_d_q <= {rst_d_q[0], ARESET};
      end

      always_ff @(posedge ACLK) begin
         if (load_main) begin
            main_q <= from_skid ? skid_q : s_data_i;
         end
         if (s_xfer) begin
            skid_q <= s_data_i;
         end
      end

      always_ff @(posedge ACLK) begin
         if (ARESET || rst_d_q[0]) begin
            state_q <= st_zero;
            ready_q <= 1'b0;
         end else if (rst_d_q[1]) begin
            // release ready one cycle after reset
            ready_q <= 1'b1;
         end else begin
            case (state_q)
               st_zero: begin
                  if (s_xfer) state_q <= st_one;
               end
               st_one: begin
                  if (m_ready_i && !s_xfer) begin
                     state_q <= st_zero;
                  end else if (!m_ready_i && s_xfer) begin
                     state_q <= st_two;
                     ready_q <= 1'b0;
                  end
               end
               st_two: begin
                  if (m_ready_i) begin
                     state_q <= st_one;
                     ready_q <= 1'b1;
                  end
               end
               default: state_q <= st_zero;
            endcase
         end
      end

      assign s_ready_o = ready_q;
      assign m_valid_o = state_q[0];
      assign m_data_o  = main_q;

   end else if (mode == SLICE_LIGHT) begin : g_light

      // one register, takes and offers in turn
      payload_t   hold_q;
      logic       valid_q;
      logic       ready_q;
      logic [1:0] rst_d_q;

      always_ff @(posedge ACLK) begin
         rst_d_q <= {rst_d_q[0], ARESET};
      end

      always_ff @(posedge ACLK) begin
         if (s_valid_i && ready_q) begin
            hold_q <= s_data_i;
         end
      end

      always_ff @(posedge ACLK) begin
         if (ARESET || rst_d_q[0]) begin
            ready_q <= 1'b0;
            valid_q <= 1'b0;
         end else if (rst_d_q[1]) begin
            ready_q <= 1'b1;
         end else if (valid_q && m_ready_i) begin
            ready_q <= 1'b1;
            valid_q <= 1'b0;
         end else if (s_valid_i && ready_q) begin
            ready_q <= 1'b0;
            valid_q <= 1'b1;
         end
      end

      assign s_ready_o = ready_q;
      assign m_valid_o = valid_q;
      assign m_data_o  = hold_q;

   end else begin : g_pass

      assign m_data_o  = s_data_i;
      assign m_valid_o = s_valid_i;
      assign s_ready_o = m_ready_i;

   end

endmodule

//--- logic/rr_stream_arbiter.sv
`timescale 1ns/10ps

module rr_stream_arbiter #(
   parameter int n_src = 2
) (
   input  logic                                  ACLK,
   input  logic                                  ARESET,
   input  stream_pkg::stream_word_t [n_src-1:0]  req_data_i,
   input  logic                     [n_src-1:0]  req_valid_i,
   output logic                     [n_src-1:0]  req_ready_o,
   output stream_pkg::tagged_word_t              m_data_o,
   output logic                                  m_valid_o,
   input  logic                                  m_ready_i
);

   import stream_pkg::*;

   logic             lock_q;
   logic [SRC_W-1:0] grant_q;
   logic [SRC_W-1:0] prio_q;
   logic [SRC_W-1:0] sel;
   logic [SRC_W-1:0] next_prio;
   logic             xfer;

   // **************************************
   // source selection
   // **************************************

   // held grant while a packet is open, else round-robin from prio_q
   always_comb begin : pick
      int   idx;
      logic found;
      idx   = 0;
      found = 1'b0;
      sel   = grant_q;
      if (!lock_q) begin
         sel = prio_q;
         for (int k = 0; k < n_src; k++) begin
            idx = (int'(prio_q) + k) % n_src;
            if (!found && req_valid_i[idx]) begin
               sel   = SRC_W'(idx);
               found = 1'b1;
            end
         end
      end
   end

   assign m_valid_o = req_valid_i[sel];
   assign m_data_o  = '{src: sel, word: req_data_i[sel]};
   assign xfer      = m_valid_o & m_ready_i;

   // only the selected source sees the downstream ready
   always_comb begin
      req_ready_o      = '0;
      req_ready_o[sel] = m_ready_i;
   end

   assign next_prio = SRC_W'((int'(sel) + 1) % n_src);

   // **************************************
   // packet lock and priority
   // **************************************

   always_ff @(posedge ACLK) begin
      if (ARESET) begin
         lock_q  <= 1'b0;
         grant_q <= '0;
         prio_q  <= '0;
      end else if (xfer) begin
         if (m_data_o.word.last) begin
            // packet done, move priority past this source
            lock_q <= 1'b0;
            prio_q <= next_prio;
         end else begin
            lock_q  <= 1'b1;
            grant_q <= sel;
         end
      end
   end

endmodule

//--- logic/stream_merge_top.sv
`timescale 1ns/10ps

module stream_merge_top #(
   parameter stream_pkg::slice_mode_e in_mode  = stream_pkg::SLICE_FULL,
   parameter stream_pkg::slice_mode_e out_mode = stream_pkg::SLICE_FULL
) (
   input  logic                     ACLK,
   input  logic                     ARESET,
   input  stream_pkg::stream_word_t s0_data_i,
   input  logic                     s0_valid_i,
   output logic                     s0_ready_o,
   input  stream_pkg::stream_word_t s1_data_i,
   input  logic                     s1_valid_i,
   output logic                     s1_ready_o,
   output stream_pkg::tagged_word_t m_data_o,
   output logic                     m_valid_o,
   input  logic                     m_ready_i
);

   import stream_pkg::*;

   localparam int n_src = 2;

   stream_word_t [n_src-1:0] in_data;
   logic         [n_src-1:0] in_valid;
   logic         [n_src-1:0] in_ready;
   tagged_word_t             arb_data;
   logic                     arb_valid;
   logic                     arb_ready;

   // **************************************
   // input slices
   // **************************************

   axis_reg_slice #(.payload_t(stream_word_t), .mode(in_mode)) s0_slice_i (
      .ACLK      (ACLK),
      .ARESET    (ARESET),
      .s_data_i  (s0_data_i),
      .s_valid_i (s0_valid_i),
      .s_ready_o (s0_ready_o),
      .m_data_o  (in_data[0]),
      .m_valid_o (in_valid[0]),
      .m_ready_i (in_ready[0])
   );

   axis_reg_slice #(.payload_t(stream_word_t), .mode(in_mode)) s1_slice_i (
      .ACLK      (ACLK),
      .ARESET    (ARESET),
      .s_data_i  (s1_data_i),
      .s_valid_i (s1_valid_i),
      .s_ready_o (s1_ready_o),
      .m_data_o  (in_data[1]),
      .m_valid_o (in_valid[1]),
      .m_ready_i (in_ready[1])
   );

   // **************************************
   // merge and output slice
   // **************************************

   rr_stream_arbiter #(.n_src(n_src)) arb_i (
      .ACLK        (ACLK),
      .ARESET      (ARESET),
      .req_data_i  (in_data),
      .req_valid_i (in_valid),
      .req_ready_o (in_ready),
      .m_data_o    (arb_data),
      .m_valid_o   (arb_valid),
      .m_ready_i   (arb_ready)
   );

   axis_reg_slice #(.payload_t(tagged_word_t), .mode(out_mode)) out_slice_i (
      .ACLK      (ACLK),
      .ARESET    (ARESET),
      .s_data_i  (arb_data),
      .s_valid_i (arb_valid),
      .s_ready_o (arb_ready),
      .m_data_o  (m_data_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i)
   );

endmodule

//--- logic/stream_pkg.sv
package stream_pkg;

   // **************************************
   // payload widths
   // **************************************

   localparam int DATA_W = 32;

   // two sources fit in one tag bit
   localparam int SRC_W = 1;

   // **************************************
   // stream words
   // **************************************

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } stream_word_t;

   // word as it leaves the merger
   typedef struct packed {
      logic [SRC_W-1:0] src;
      stream_word_t     word;
   } tagged_word_t;

   // **************************************
   // register slice modes
   // **************************************

   typedef enum logic [1:0] {
      SLICE_FULL  = 2'd0,
      SLICE_LIGHT = 2'd1,
      SLICE_PASS  = 2'd2
   } slice_mode_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the stream merger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module stream_merge_tb -o sim_stream_merge
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/sim_stream_merge 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
   exit 0
else
   exit 1
fi

//--- src.f
logic/stream_pkg.sv
logic/axis_reg_slice.sv
logic/rr_stream_arbiter.sv
logic/stream_merge_top.sv
verif/stream_merge_properties.sv
verif/stream_merge_tb.sv

//--- verif/stream_merge_properties.sv
`timescale 1ns/10ps

module stream_merge_properties (
   input logic                     ACLK,
   input logic                     ARESET,
   input stream_pkg::stream_word_t s0_data_i,
   input logic                     s0_valid_i,
   input logic                     s0_ready_i,
   input stream_pkg::stream_word_t s1_data_i,
   input logic                     s1_valid_i,
   input logic                     s1_ready_i,
   input stream_pkg::tagged_word_t m_data_i,
   input logic                     m_valid_i,
   input logic                     m_ready_i
);

   // a stalled word holds until taken
   out_stable: assert property (@(posedge ACLK) disable iff (ARESET)
      m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_data_i))
      else $error("output word changed while stalled");

   s0_stable: assert property (@(posedge ACLK) disable iff (ARESET)
      s0_valid_i && !s0_ready_i |=> s0_valid_i && $stable(s0_data_i))
      else $error("source 0 word changed while stalled");

   s1_stable: assert property (@(posedge ACLK) disable iff (ARESET)
      s1_valid_i && !s1_ready_i |=> s1_valid_i && $stable(s1_data_i))
      else $error("source 1 word changed while stalled");

   // reset edge clears the output valid
   out_quiet: assert property (@(posedge ACLK) ARESET |=> !m_valid_i)
      else $error("output valid high in reset");

   in_quiet: assert property (@(posedge ACLK) ARESET |=> !s0_ready_i && !s1_ready_i)
      else $error("input ready high in reset");

endmodule

bind stream_merge_top stream_merge_properties props_i (
   .ACLK(ACLK), .ARESET(ARESET),
   .s0_data_i(s0_data_i), .s0_valid_i(s0_valid_i), .s0_ready_i(s0_ready_o),
   .s1_data_i(s1_data_i), .s1_valid_i(s1_valid_i), .s1_ready_i(s1_ready_o),
   .m_data_i(m_data_o), .m_valid_i(m_valid_o), .m_ready_i(m_ready_i)
);

//--- verif/stream_merge_tb.sv
`timescale 1ns/10ps

module stream_merge_tb;

   import stream_pkg::*;

   localparam int words_per_src = 200;
   localparam int lat_words     = 4;
   localparam int timeout_cyc   = 2 * words_per_src * 50;

   logic         ACLK, ARESET;
   stream_word_t s0_data, s1_data;
   logic         s0_valid, s1_valid, s0_ready, s1_ready;
   tagged_word_t m_data;
   logic         m_valid, m_ready;

   // stimulus and model state
   logic [31:0]      lfsr_state;
   stream_word_t     offer [2];
   logic [1:0]       offer_valid;
   stream_word_t     model_q [2][$];
   int               gap [2], pkt_left [2], sent [2];
   int               cyc, tick, in_cyc, out_cnt;
   logic             rand_on, lat_armed, open_pkt;
   logic [SRC_W-1:0] open_src;

   stream_merge_top #(.in_mode(SLICE_FULL), .out_mode(SLICE_FULL)) dut_i (
      .ACLK(ACLK), .ARESET(ARESET),
      .s0_data_i(s0_data), .s0_valid_i(s0_valid), .s0_ready_o(s0_ready),
      .s1_data_i(s1_data), .s1_valid_i(s1_valid), .s1_ready_o(s1_ready),
      .m_data_o(m_data), .m_valid_o(m_valid), .m_ready_i(m_ready)
   );

   always #50 ACLK = ~ACLK;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Done: errors found");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic offer_word(input int s);
      logic [31:0] r;
      if (!offer_valid[s] && gap[s] > 0) begin
         gap[s]--;
      end else if (!offer_valid[s] && sent[s] < words_per_src) begin
         if (pkt_left[s] == 0) begin
            take_bits(3, r);
            pkt_left[s] = int'(r[2:0]) + 1;
         end
         take_bits(32, r);
         offer[s].data  = r;
         offer[s].last  = (pkt_left[s] == 1) || (sent[s] == words_per_src - 1);
         offer_valid[s] = 1'b1;
      end
   endtask

   // transfers that happen at the coming rising edge
   task automatic watch_ports();
      logic [1:0]   rdy;
      logic [31:0]  r;
      stream_word_t exp;
      rdy = {s1_ready, s0_ready};
      for (int s = 0; s < 2; s++) begin
         if (offer_valid[s] && rdy[s]) begin
            model_q[s].push_back(offer[s]);
            sent[s]++;
            pkt_left[s]    = offer[s].last ? 0 : pkt_left[s] - 1;
            offer_valid[s] = 1'b0;
            take_bits(2, r);
            gap[s] = int'(r[1:0]);
            if (s == 0) in_cyc = cyc;
         end
      end
      if (m_valid && m_ready) begin
         assert (model_q[m_data.src].size() > 0) else
            stop_run($sformatf("Mismatch at %0t: word from source %0d not expected",
                               $time, m_data.src));
         exp = model_q[m_data.src].pop_front();
         assert (m_data.word == exp) else
            stop_run($sformatf("Mismatch at %0t: source %0d expected %h got %h",
                               $time, m_data.src, exp, m_data.word));
         assert (!open_pkt || m_data.src == open_src) else
            stop_run($sformatf("Mismatch at %0t: source %0d broke into packet of %0d",
                               $time, m_data.src, open_src));
         if (lat_armed) begin
            assert (cyc - in_cyc == 2) else
               stop_run($sformatf("Mismatch at %0t: latency %0d edges, expected 2",
                                  $time, cyc - in_cyc));
         end
         open_pkt = !m_data.word.last;
         open_src = m_data.src;
         out_cnt++;
      end
   endtask

   task automatic step();
      logic [31:0] r;
      @(negedge ACLK);
      m_ready = 1'b1;
      if (rand_on) begin
         offer_word(0);
         offer_word(1);
         take_bits(4, r);
         m_ready = (r[3:0] >= 4'd5);
      end
      s0_valid = offer_valid[0];
      s0_data  = offer[0];
      s1_valid = offer_valid[1];
      s1_data  = offer[1];
      #1;
      watch_ports();
      cyc++;
   endtask

   always @(posedge ACLK) begin
      tick++;
      if (tick >= timeout_cyc) stop_run("Timeout: the run did not finish in time");
   end

   initial begin
      logic [31:0] r;
      ACLK = 1'b0;
      ARESET = 1'b1;
      {s0_valid, s1_valid, m_ready} = '0;
      s0_data = '0;
      s1_data = '0;
      lfsr_state = 32'd81471;
      offer[0] = '0;
      offer[1] = '0;
      offer_valid = '0;
      gap = '{0, 0};
      pkt_left = '{0, 0};
      sent = '{0, 0};
      {cyc, tick, in_cyc, out_cnt} = '0;
      {rand_on, lat_armed, open_pkt, open_src} = '0;

      // ***************************************
      // reset
      // ***************************************
      repeat (16) begin
         @(negedge ACLK);
         assert (!m_valid && !s0_ready && !s1_ready) else
            stop_run($sformatf("Mismatch at %0t: valid or ready high in reset", $time));
      end
      ARESET = 1'b0;
      @(negedge ACLK);
      assert (!m_valid && !s0_ready && !s1_ready) else
         stop_run($sformatf("Mismatch at %0t: valid or ready high right after reset", $time));
      @(negedge ACLK);
      assert (s0_ready && s1_ready) else
         stop_run($sformatf("Mismatch at %0t: input ready still low", $time));

      // ***************************************
      // random traffic, then idle latency
      // ***************************************
      rand_on = 1'b1;
      while (sent[0] < words_per_src || sent[1] < words_per_src) step();
      rand_on = 1'b0;
      while (model_q[0].size() != 0 || model_q[1].size() != 0) step();
      lat_armed = 1'b1;
      for (int k = 0; k < lat_words; k++) begin
         take_bits(32, r);
         offer[0] = '{data: r, last: 1'b1};
         offer_valid[0] = 1'b1;
         step();
         assert (!offer_valid[0]) else stop_run("Source 0 word was refused by an idle merger");
         while (model_q[0].size() != 0) step();
      end

      assert (!open_pkt) else stop_run("A packet was left open on the output");
      assert (out_cnt == 2 * words_per_src + lat_words) else
         stop_run($sformatf("Mismatch at %0t: %0d words out", $time, out_cnt));
      $display("Done: no errors");
      $finish;
   end

endmodule
